/* rtl/apb_mem_port.sv */
`timescale 1ns/1ps

module apb_mem_port
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  addr_t           paddr,
    input  logic [XLEN-1:0] pwdata,
    output logic [XLEN-1:0] prdata,
    output logic            pready,
    output logic            pslverr,
    output mem_req_t        req,
    input  logic            gnt,
    input  mem_resp_t       resp
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t state;
    logic   access;

    assign access = psel && penable;

    // keep asking until the arbiter takes it
    always_comb begin
        req.valid = (state == ST_IDLE) && access;
        req.addr  = paddr;
        req.wen   = pwrite;
        req.wdata = pwdata;
    end

    assign pready  = (state == ST_WAIT) && resp.valid;
    assign prdata  = resp.rdata;
    assign pslverr = pready && resp.error;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req.valid && gnt) state <= ST_WAIT;
                ST_WAIT: if (resp.valid) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* rtl/bimodal_predictor.sv */
`timescale 1ns/1ps

module bimodal_predictor
    import fetch_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  addr_t    pc,
    input  br_info_t br_info,
    output logic     taken
);

    logic [1:0] counters [BP_ENTRIES];

    logic [BP_IW-1:0] rd_idx;
    logic [BP_IW-1:0] wr_idx;
    logic [1:0]       wr_cnt;

    assign rd_idx = pc[BP_IW+1:2];
    assign wr_idx = br_info.pc[BP_IW+1:2];
    assign wr_cnt = counters[wr_idx];

    // upper half of the counter range predicts taken
    assign taken = counters[rd_idx][1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                // weakly not-taken
                counters[i] <= 2'd1;
            end
        end else if (br_info.valid) begin
            if (br_info.taken) begin
                if (wr_cnt != 2'd3) begin
                    counters[wr_idx] <= wr_cnt + 2'd1;
                end
            end else begin
                if (wr_cnt != 2'd0) begin
                    counters[wr_idx] <= wr_cnt - 2'd1;
                end
            end
        end
    end

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    localparam int XLEN        = 32;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_AW      = 8;
    localparam int QUEUE_DEPTH = 8;

    // predictor indexed by pc[7:2]
    localparam int BP_ENTRIES  = 64;
    localparam int BP_IW       = $clog2(BP_ENTRIES);

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013;

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] inst_t;

    typedef struct packed {
        logic              valid;
        addr_t             addr;
        logic              wen;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   rdata;
        logic              error;
    } mem_resp_t;

    // queue and decode payload
    typedef struct packed {
        addr_t  addr;
        inst_t  inst;
        logic   error;
    } fetch_entry_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;
    } redirect_t;

    typedef struct packed {
        logic   valid;
        addr_t  pc;
        logic   taken;
    } br_info_t;

endpackage

/* rtl/fetch_subsys_top.sv */
`timescale 1ns/1ps

module fetch_subsys_top
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  addr_t           paddr,
    input  logic [XLEN-1:0] pwdata,
    output logic [XLEN-1:0] prdata,
    output logic            pready,
    output logic            pslverr,
    input  logic            run,
    input  redirect_t       redirect,
    input  br_info_t        br_info,
    output fetch_entry_t    decode_entry,
    output logic            decode_valid,
    input  logic            decode_ready
);

    mem_req_t     fetch_req;
    mem_req_t     apb_req;
    mem_req_t     mem_req;
    mem_resp_t    mem_resp;
    mem_resp_t    fetch_resp;
    mem_resp_t    apb_resp;
    logic         fetch_gnt;
    logic         apb_gnt;
    addr_t        pred_pc;
    logic         pred_taken;
    logic         q_wvalid;
    logic         q_wready;
    fetch_entry_t q_wdata;

    fetch_unit u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .redirect   (redirect),
        .mem_req    (fetch_req),
        .mem_gnt    (fetch_gnt),
        .mem_resp   (fetch_resp),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken),
        .q_wready   (q_wready),
        .q_wvalid   (q_wvalid),
        .q_wdata    (q_wdata)
    );

    bimodal_predictor u_bp (
        .clk     (clk),
        .arst_n  (arst_n),
        .pc      (pred_pc),
        .br_info (br_info),
        .taken   (pred_taken)
    );

    sync_queue #(
        .payload_t (fetch_entry_t),
        .DEPTH     (QUEUE_DEPTH)
    ) u_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .kill   (redirect.valid),
        .wvalid (q_wvalid),
        .wdata  (q_wdata),
        .wready (q_wready),
        .rready (decode_ready),
        .rvalid (decode_valid),
        .rdata  (decode_entry)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_gnt  (fetch_gnt),
        .apb_req    (apb_req),
        .apb_gnt    (apb_gnt),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .fetch_resp (fetch_resp),
        .apb_resp   (apb_resp)
    );

    inst_mem u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .resp   (mem_resp)
    );

    apb_mem_port u_apb (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (apb_req),
        .gnt     (apb_gnt),
        .resp    (apb_resp)
    );

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         run,
    input  redirect_t    redirect,
    output mem_req_t     mem_req,
    input  logic         mem_gnt,
    input  mem_resp_t    mem_resp,
    output addr_t        pred_pc,
    input  logic         pred_taken,
    input  logic         q_wready,
    output logic         q_wvalid,
    output fetch_entry_t q_wdata
);

    addr_t pc;
    addr_t request_pc;
    logic  requested;

    logic         resp_ok;
    logic         word_ok;
    inst_t        word;
    logic [6:0]   opcode;
    logic [31:0]  imm_j;
    logic [31:0]  imm_b;
    logic         is_jal;
    logic         is_br;
    addr_t        seq_addr;
    addr_t        br_addr;
    addr_t        next_addr;
    addr_t        fetch_addr;
    logic         issue;

    assign resp_ok = requested && mem_resp.valid;
    assign word_ok = resp_ok && !mem_resp.error;
    assign word    = mem_resp.rdata;
    assign opcode  = word[6:0];

    // J and B immediates, sign extended
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};

    // erroneous words are never decoded
    assign is_jal = word_ok && (opcode == OP_JAL);
    assign is_br  = word_ok && (opcode == OP_BRANCH);

    assign pred_pc  = request_pc;
    assign seq_addr = request_pc + 32'd4;
    assign br_addr  = pred_taken ? request_pc + imm_b : seq_addr;

    always_comb begin
        if (is_jal) begin
            next_addr = request_pc + imm_j;
        end else if (is_br) begin
            next_addr = br_addr;
        end else begin
            next_addr = seq_addr;
        end
    end

    // a returning word steers the request issued in the same cycle
    assign fetch_addr = resp_ok ? next_addr : pc;
    assign issue      = mem_req.valid && mem_gnt;

    always_comb begin
        mem_req.valid = run && !redirect.valid && q_wready;
        mem_req.addr  = fetch_addr;
        mem_req.wen   = 1'b0;
        mem_req.wdata = '0;
    end

    // response in flight is dropped on redirect
    assign q_wvalid = resp_ok && !redirect.valid;

    always_comb begin
        q_wdata.addr  = request_pc;
        q_wdata.inst  = mem_resp.error ? INST_NOP : word;
        q_wdata.error = mem_resp.error;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= RESET_PC;
            request_pc <= RESET_PC;
            requested  <= 1'b0;
        end else if (redirect.valid) begin
            // first request goes out next cycle
            pc         <= redirect.addr;
            request_pc <= redirect.addr;
            requested  <= 1'b0;
        end else begin
            // holds the target while the port is busy
            pc        <= fetch_addr;
            requested <= issue;
            if (issue) begin
                request_pc <= fetch_addr;
            end
        end
    end

endmodule

/* rtl/inst_mem.sv */
`timescale 1ns/1ps

module inst_mem
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mem_req_t  req,
    output mem_resp_t resp
);

    logic [XLEN-1:0] words [MEM_WORDS];

    logic [MEM_AW-1:0] idx;
    logic              in_range;
    logic              rd_valid;
    logic [XLEN-1:0]   rd_data;
    logic              rd_error;

    assign idx      = req.addr[MEM_AW+1:2];
    assign in_range = (req.addr >> 2) < MEM_WORDS;

    // out of range writes are dropped
    always_ff @(posedge clk) begin
        if (req.valid && req.wen && in_range) begin
            words[idx] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rd_data  <= in_range ? words[idx] : '0;
            rd_error <= !in_range;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.valid;
        end
    end

    always_comb begin
        resp.valid = rd_valid;
        resp.rdata = rd_data;
        resp.error = rd_error;
    end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mem_req_t  fetch_req,
    output logic      fetch_gnt,
    input  mem_req_t  apb_req,
    output logic      apb_gnt,
    output mem_req_t  mem_req,
    input  mem_resp_t mem_resp,
    output mem_resp_t fetch_resp,
    output mem_resp_t apb_resp
);

    // owner of the access granted last cycle
    logic owner_apb;

    // apb always wins
    assign apb_gnt   = apb_req.valid;
    assign fetch_gnt = fetch_req.valid && !apb_req.valid;
    assign mem_req   = apb_gnt ? apb_req : fetch_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner_apb <= 1'b0;
        end else begin
            owner_apb <= apb_gnt;
        end
    end

    always_comb begin
        fetch_resp       = mem_resp;
        fetch_resp.valid = mem_resp.valid && !owner_apb;
        apb_resp         = mem_resp;
        apb_resp.valid   = mem_resp.valid && owner_apb;
    end

endmodule

/* rtl/sync_queue.sv */
`timescale 1ns/1ps

module sync_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     kill,
    input  logic     wvalid,
    input  payload_t wdata,
    output logic     wready,
    input  logic     rready,
    output logic     rvalid,
    output payload_t rdata
);

    payload_t store [DEPTH];

    logic [$clog2(DEPTH)-1:0]   rptr;
    logic [$clog2(DEPTH)-1:0]   wptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_write;
    logic                       do_read;

    assign rvalid   = count != 0;
    assign rdata    = store[rptr];
    assign do_write = wvalid && (count != DEPTH);
    assign do_read  = rready && rvalid;

    // look-ahead: leave room for the word still in flight
    assign wready = (count <= DEPTH - 2) || ((count == DEPTH - 1) && !wvalid);

    always_ff @(posedge clk) begin
        if (do_write && !kill) begin
            store[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else if (kill) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == DEPTH - 1) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == DEPTH - 1) ? '0 : rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_top -f sources.f -o Vtb_fetch_top

./obj_dir/Vtb_fetch_top | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sources.f */
rtl/fetch_pkg.sv
rtl/sync_queue.sv
rtl/bimodal_predictor.sv
rtl/fetch_unit.sv
rtl/mem_arbiter.sv
rtl/inst_mem.sv
rtl/apb_mem_port.sv
rtl/fetch_subsys_top.sv
verification/fetch_chk.sv
verification/tb_fetch_top.sv

/* verification/fetch_chk.sv */
`timescale 1ns/1ps

module fetch_chk
    import fetch_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input logic         fetch_gnt,
    input logic         apb_gnt,
    input logic         fetch_resp_valid,
    input logic         apb_resp_valid,
    input logic         penable,
    input logic         pready,
    input logic         redirect_valid,
    input logic         decode_valid,
    input logic         decode_ready,
    input fetch_entry_t decode_entry
);

    int fail_count = 0;

    // one memory port, so each response goes back to the one peer granted before
    a_one_grant: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fetch_gnt || apb_gnt)
            |=> (fetch_resp_valid == $past(fetch_gnt)) && (apb_resp_valid == $past(apb_gnt))
    ) else begin
        fail_count++;
        $error("memory response not returned to the single granted peer");
    end

    // a stalled entry holds until taken or killed
    a_decode_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        decode_valid && !decode_ready && !redirect_valid
            |=> decode_valid && $stable(decode_entry)
    ) else begin
        fail_count++;
        $error("decode entry changed while stalled");
    end

    // pready in the second access cycle and for one cycle only
    a_pready_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(penable) |=> pready ##1 !pready
    ) else begin
        fail_count++;
        $error("pready not a single pulse in the second access cycle");
    end

endmodule

bind fetch_subsys_top fetch_chk u_chk (
    .clk              (clk),
    .arst_n           (arst_n),
    .fetch_gnt        (fetch_gnt),
    .apb_gnt          (apb_gnt),
    .fetch_resp_valid (fetch_resp.valid),
    .apb_resp_valid   (apb_resp.valid),
    .penable          (penable),
    .pready           (pready),
    .redirect_valid   (redirect.valid),
    .decode_valid     (decode_valid),
    .decode_ready     (decode_ready),
    .decode_entry     (decode_entry)
);

/* verification/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int K_PLAIN  = 0;
    localparam int K_JAL    = 1;
    localparam int K_BRANCH = 2;

    logic            clk;
    logic            arst_n;
    logic            psel;
    logic            penable;
    logic            pwrite;
    addr_t           paddr;
    logic [XLEN-1:0] pwdata;
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
    logic            run;
    redirect_t       redirect;
    br_info_t        br_info;
    fetch_entry_t    decode_entry;
    logic            decode_valid;
    logic            decode_ready;

    // reference model
    inst_t      prog     [MEM_WORDS];
    int         kind     [MEM_WORDS];
    int         jump_off [MEM_WORDS];
    logic [1:0] counters [BP_ENTRIES];
    addr_t      exp_addr;

    logic [31:0] rng_state;
    int          errors;

    fetch_subsys_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .run          (run),
        .redirect     (redirect),
        .br_info      (br_info),
        .decode_entry (decode_entry),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic inst_t encode_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic inst_t encode_branch(input logic [12:0] off, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic fetch_entry_t model_entry(input addr_t a);
        fetch_entry_t e;
        e.addr = a;
        if ((a >> 2) < MEM_WORDS) begin
            e.inst  = prog[a[MEM_AW+1:2]];
            e.error = 1'b0;
        end else begin
            e.inst  = INST_NOP;
            e.error = 1'b1;
        end
        return e;
    endfunction

    function automatic addr_t model_next(input addr_t a);
        int w;
        if ((a >> 2) >= MEM_WORDS) begin
            return a + 32'd4;
        end
        w = int'(a[MEM_AW+1:2]);
        if (kind[w] == K_JAL) begin
            return a + addr_t'(jump_off[w]);
        end
        if (kind[w] == K_BRANCH && counters[a[7:2]] >= 2'd2) begin
            return a + addr_t'(jump_off[w]);
        end
        return a + 32'd4;
    endfunction

    function automatic void train_model(input addr_t pc, input logic taken);
        if (taken && counters[pc[7:2]] != 2'd3) begin
            counters[pc[7:2]] = counters[pc[7:2]] + 2'd1;
        end else if (!taken && counters[pc[7:2]] != 2'd0) begin
            counters[pc[7:2]] = counters[pc[7:2]] - 2'd1;
        end
    endfunction

    task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp);
        if (got !== exp) begin
            errors++;
            $display("error decode_entry got %h exp %h", got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timeout: the DUT never delivered %s", what);
        $display("errors: %0d", errors);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic apb_xfer(input logic wr, input addr_t a, input logic [XLEN-1:0] wd,
                            output logic [XLEN-1:0] rd, output logic err);
        int waited;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = wd;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 50) begin
                stop_on_timeout("an APB pready");
            end
        end while (!pready);
        rd  = prdata;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic        near_exit;
        int          woff;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r           = next_rand();
            near_exit   = (i >= 196 && i < 200);
            woff        = int'(r[7:4]) + 1;
            kind[i]     = K_PLAIN;
            jump_off[i] = 4;
            prog[i]     = (next_rand() & 32'hffff_8f80) | 32'h0000_0013;
            if (i == 200) begin
                // target far past the end of memory
                kind[i]     = K_JAL;
                jump_off[i] = 32'h800;
                prog[i]     = encode_jal(21'h800, 5'd1);
            end else if (!near_exit && r[3:0] >= 4'd13) begin
                if ((r[8] && i >= woff) || i + woff >= MEM_WORDS) begin
                    woff = -woff;
                end
                kind[i]     = K_BRANCH;
                jump_off[i] = woff * 4;
                prog[i]     = encode_branch(13'(woff * 4), r[13:9], r[18:14], r[21:19]);
            end else if (!near_exit && r[3:0] >= 4'd10) begin
                kind[i]     = K_JAL;
                jump_off[i] = woff * 4;
                prog[i]     = encode_jal(21'(woff * 4), r[13:9]);
            end
        end
    endtask

    task automatic load_program();
        logic [XLEN-1:0] rd;
        logic            err;
        addr_t           a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            apb_xfer(1'b1, addr_t'(i) << 2, prog[i], rd, err);
            check_bit("pslverr", err, 1'b0);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            apb_xfer(1'b0, addr_t'(i) << 2, '0, rd, err);
            check_word("prdata", rd, prog[i]);
            check_bit("pslverr", err, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            a = 32'h400 + (next_rand() & 32'hffc);
            apb_xfer(1'b1, a, next_rand(), rd, err);
            check_bit("pslverr", err, 1'b1);
            apb_xfer(1'b0, a, '0, rd, err);
            check_bit("pslverr", err, 1'b1);
            // in-range word with the same low bits is untouched
            apb_xfer(1'b0, a & 32'h3fc, '0, rd, err);
            check_word("prdata", rd, prog[a[MEM_AW+1:2]]);
        end
    endtask

    task automatic train_predictor(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            r             = next_rand();
            br_info.valid = 1'b1;
            br_info.pc    = r & 32'hffff_fffc;
            br_info.taken = r[12] | r[13];
            train_model(br_info.pc, br_info.taken);
        end
        @(negedge clk);
        br_info.valid = 1'b0;
    endtask

    task automatic start_fetch(input addr_t a, input logic with_redirect);
        @(negedge clk);
        decode_ready   = 1'b0;
        run            = 1'b1;
        redirect.valid = with_redirect;
        redirect.addr  = a;
        exp_addr       = a;
        @(negedge clk);
        redirect.valid = 1'b0;
    endtask

    task automatic stop_fetch();
        @(negedge clk);
        decode_ready = 1'b0;
        run          = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    // accept n entries and check each against the model
    task automatic consume(input int n, input logic allow_redirect);
        logic [31:0] r;
        int          accepted;
        int          idle;
        accepted = 0;
        idle     = 0;
        while (accepted < n) begin
            @(negedge clk);
            r              = next_rand();
            redirect.valid = 1'b0;
            if (allow_redirect && r[4:0] == 5'd0) begin
                decode_ready   = 1'b0;
                redirect.valid = 1'b1;
                redirect.addr  = addr_t'(r[15:8]) << 2;
                exp_addr       = redirect.addr;
                idle           = 0;
            end else begin
                decode_ready = r[5] | r[6];
                if (decode_ready && decode_valid) begin
                    check_entry(decode_entry, model_entry(exp_addr));
                    exp_addr = model_next(exp_addr);
                    accepted++;
                    idle = 0;
                end else begin
                    idle++;
                    if (idle > 200) begin
                        stop_on_timeout("a decode entry");
                    end
                end
            end
        end
    endtask

    task automatic backpressure_with_apb();
        addr_t           reads [24];
        logic [XLEN-1:0] rd;
        logic            err;
        for (int i = 0; i < 24; i++) begin
            reads[i] = next_rand() & 32'h3fc;
        end
        start_fetch(next_rand() & 32'h3fc, 1'b1);
        fork
            begin
                repeat (30) @(negedge clk);
                check_bit("decode_valid", decode_valid, 1'b1);
                consume(48, 1'b0);
            end
            begin
                for (int i = 0; i < 24; i++) begin
                    apb_xfer(1'b0, reads[i], '0, rd, err);
                    check_word("prdata", rd, prog[reads[i][MEM_AW+1:2]]);
                    check_bit("pslverr", err, 1'b0);
                end
            end
        join
        stop_fetch();
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        run          = 1'b0;
        redirect     = '0;
        br_info      = '0;
        decode_ready = 1'b0;
        rng_state    = 32'h4b4b1bfe;
        errors       = 0;
        for (int i = 0; i < BP_ENTRIES; i++) begin
            counters[i] = 2'd1;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        build_program();
        load_program();

        // round 0 fetches from the reset pc, round 1 runs into the exit jump
        for (int r = 0; r < 12; r++) begin
            if (r > 0) begin
                train_predictor(16);
            end
            if (r == 0) begin
                start_fetch(RESET_PC, 1'b0);
            end else if (r == 1) begin
                start_fetch(32'd196 << 2, 1'b1);
            end else begin
                start_fetch(next_rand() & 32'h3fc, 1'b1);
            end
            consume(40, r != 1);
            stop_fetch();
        end

        backpressure_with_apb();

        errors = errors + dut0.u_chk.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
